//--- dcache_pkg.sv
// shared widths and types for the miss-issue path; the message encoding must match the coherence side
`default_nettype none

package dcache_pkg;

	// ------------------------------
	// field widths
	// ------------------------------
	localparam int TAG_W  = 10;
	localparam int IDX_W  = 4;
	localparam int WORD_W = 64;

	// coherence request type
	// NONE encodes as zero so an empty forward result is all zero
	typedef enum logic [1:0] {
		NONE  = 2'b00,
		GET_S = 2'b01,
		GET_M = 2'b10,
		PUT_M = 2'b11
	} message_t;

	// ------------------------------
	// bundles
	// ------------------------------

	// line address, tag above index
	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic [IDX_W-1:0] idx;
	} line_addr_t;

	// one miss request as allocated, queued and sent to the bus
	typedef struct packed {
		line_addr_t        addr;
		logic [WORD_W-1:0] data;
		message_t          message;
		// set for store-conditional misses
		logic              stq_c_flag;
	} mshr_req_t;

	// load forwarding result
	typedef struct packed {
		logic [WORD_W-1:0] data;
		message_t          message;
	} lq_fwd_t;

endpackage : dcache_pkg

`default_nettype wire

//--- rps_sel.sv
// N must be a power of two of at least 2, ptr_i is the first position checked and lower ones follow
`timescale 1ns/1ps
`default_nettype none

module rps_sel #(
	parameter int N = 4
) (
	input  wire logic                 en_i,
	input  wire logic [N-1:0]         req_i,
	input  wire logic [$clog2(N)-1:0] ptr_i,
	output logic      [N-1:0]         gnt_o
);

	localparam int PTR_W = $clog2(N);

	// ------------------------------
	// downward rotating scan
	// ------------------------------
	always_comb begin
		logic             found;
		logic [PTR_W-1:0] pos;
		gnt_o = '0;
		found = 1'b0;
		pos   = ptr_i;
		for (int k = 0; k < N; k++) begin
			// pointer arithmetic wraps 0 back to N-1
			pos = ptr_i - PTR_W'(k);
			if (en_i && !found && req_i[pos]) begin
				gnt_o[pos] = 1'b1;
				found      = 1'b1;
			end
		end
	end

	// at most one grant, whatever the pointer and request mix
	always_comb begin
		a_gnt_onehot0 : assert ($onehot0(gnt_o))
			else $error("rps_sel grant not one-hot: %b", gnt_o);
	end

endmodule : rps_sel

`default_nettype wire

//--- mshr_iss.sv
// MSHR_NUM must be a power of two of at least 2, alloc_en_i must stay low while full_o is high
`timescale 1ns/1ps
`default_nettype none

module mshr_iss import dcache_pkg::*; #(
	parameter int MSHR_NUM = 4
) (
	input  wire logic       clk,
	input  wire logic       rst,

	// allocate at tail
	input  wire logic       alloc_en_i,
	input  wire mshr_req_t  alloc_req_i,

	// issue from head
	input  wire logic       iss_ack_i,
	output logic            iss_vld_o,
	output mshr_req_t       iss_req_o,
	output logic            full_o,

	// store lookup
	input  wire line_addr_t sq_addr_i,
	output logic            sq_hit_o,

	// load lookup
	input  wire line_addr_t lq_addr_i,
	output logic            lq_hit_o,
	output lq_fwd_t         lq_fwd_o
);

	localparam int PTR_W = $clog2(MSHR_NUM);

	// ------------------------------
	// queue state
	// ------------------------------
	logic [MSHR_NUM-1:0]            vld_r;
	mshr_req_t [MSHR_NUM-1:0]       ent_r;

	// pointers carry one wrap bit above the index
	logic [PTR_W:0]                 head_r;
	logic [PTR_W:0]                 tail_r;
	logic [PTR_W-1:0]               head_idx;
	logic [PTR_W-1:0]               tail_idx;

	// load lookup
	logic [MSHR_NUM-1:0]            lq_match;
	logic [MSHR_NUM-1:0]            lq_gnt;
	logic [PTR_W-1:0]               lq_ptr;

	assign head_idx = head_r[PTR_W-1:0];
	assign tail_idx = tail_r[PTR_W-1:0];

	// same slot, opposite lap
	assign full_o = (head_idx == tail_idx) && (head_r[PTR_W] != tail_r[PTR_W]);

	// head entry offered to the command stage
	assign iss_vld_o = vld_r[head_idx];
	assign iss_req_o = ent_r[head_idx];

	// ------------------------------
	// pointer and valid update
	// ------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			vld_r  <= '0;
			head_r <= '0;
			tail_r <= '0;
		end else begin
			// ack retires the head
			if (iss_ack_i) begin
				vld_r[head_idx] <= 1'b0;
				head_r          <= head_r + 1'b1;
			end
			// new miss at tail, never the same slot as an acked head
			if (alloc_en_i) begin
				vld_r[tail_idx] <= 1'b1;
				tail_r          <= tail_r + 1'b1;
			end
		end
	end

	// payload write
	always_ff @(posedge clk) begin
		if (alloc_en_i) begin
			ent_r[tail_idx] <= alloc_req_i;
		end
	end

	// ------------------------------
	// store lookup
	// ------------------------------
	// any waiting GET_M to the same line
	always_comb begin
		sq_hit_o = 1'b0;
		for (int i = 0; i < MSHR_NUM; i++) begin
			if (vld_r[i] && ent_r[i].message == GET_M && ent_r[i].addr == sq_addr_i) begin
				sq_hit_o = 1'b1;
			end
		end
	end

	// ------------------------------
	// load lookup
	// ------------------------------
	// candidates are GET_M to the same line, store-conditionals excluded
	always_comb begin
		for (int i = 0; i < MSHR_NUM; i++) begin
			lq_match[i] = vld_r[i] && ent_r[i].message == GET_M &&
				!ent_r[i].stq_c_flag && ent_r[i].addr == lq_addr_i;
		end
	end

	// tail minus one is the youngest slot, scan goes older from there
	assign lq_ptr = tail_idx - 1'b1;

	rps_sel #(
		.N(MSHR_NUM)
	) lq_sel_i (
		.en_i (1'b1),
		.req_i(lq_match),
		.ptr_i(lq_ptr),
		.gnt_o(lq_gnt)
	);

	assign lq_hit_o = |lq_gnt;

	// one-hot mux of the granted entry
	always_comb begin
		lq_fwd_o.data    = '0;
		lq_fwd_o.message = NONE;
		for (int i = 0; i < MSHR_NUM; i++) begin
			if (lq_gnt[i]) begin
				lq_fwd_o.data    = ent_r[i].data;
				lq_fwd_o.message = ent_r[i].message;
			end
		end
	end

	// ------------------------------
	// protocol checks
	// ------------------------------
	// the cache side must respect full
	a_no_alloc_full : assert property (@(posedge clk) disable iff (rst)
		alloc_en_i |-> !full_o)
		else $error("allocation while MSHR queue is full");

	// the command stage only takes a valid head
	a_no_ack_empty : assert property (@(posedge clk) disable iff (rst)
		iss_ack_i |-> iss_vld_o)
		else $error("issue ack while head entry is invalid");

endmodule : mshr_iss

`default_nettype wire

//--- bus_cmd_stage.sv
// one command in flight; bus_gnt_i is only meaningful while bus_req_o is high
`timescale 1ns/1ps
`default_nettype none

module bus_cmd_stage import dcache_pkg::*; (
	input  wire logic      clk,
	input  wire logic      rst,

	// queue head side
	input  wire logic      head_vld_i,
	input  wire mshr_req_t head_req_i,
	output logic           iss_ack_o,

	// memory bus side
	input  wire logic      bus_gnt_i,
	output logic           bus_req_o,
	output mshr_req_t      bus_cmd_o
);

	// ------------------------------
	// command register
	// ------------------------------
	logic      cmd_vld_r;
	mshr_req_t cmd_r;

	// take the head when empty or emptied by this cycle's grant
	assign iss_ack_o = head_vld_i && (!cmd_vld_r || bus_gnt_i);

	always_ff @(posedge clk) begin
		if (rst) begin
			cmd_vld_r <= 1'b0;
		end else if (iss_ack_o) begin
			// refill wins over the grant
			cmd_vld_r <= 1'b1;
		end else if (bus_gnt_i) begin
			cmd_vld_r <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (iss_ack_o) begin
			cmd_r <= head_req_i;
		end
	end

	// level request until granted
	assign bus_req_o = cmd_vld_r;
	assign bus_cmd_o = cmd_r;

	// ------------------------------
	// bus rules
	// ------------------------------
	// an ungranted request stays up with the same command
	a_cmd_hold : assert property (@(posedge clk) disable iff (rst)
		bus_req_o && !bus_gnt_i |=> bus_req_o && $stable(bus_cmd_o))
		else $error("bus command changed before grant");

endmodule : bus_cmd_stage

`default_nettype wire

//--- dcache_miss_top.sv
// MSHR_NUM must be a power of two of at least 2; up to MSHR_NUM+1 misses are outstanding
`timescale 1ns/1ps
`default_nettype none

module dcache_miss_top import dcache_pkg::*; #(
	parameter int MSHR_NUM = 4
) (
	input  wire logic       clk,
	input  wire logic       rst,

	// allocation from the cache
	input  wire logic       alloc_en_i,
	input  wire mshr_req_t  alloc_req_i,
	output logic            full_o,

	// lookups
	input  wire line_addr_t sq_addr_i,
	output logic            sq_hit_o,
	input  wire line_addr_t lq_addr_i,
	output logic            lq_hit_o,
	output lq_fwd_t         lq_fwd_o,

	// memory bus
	input  wire logic       bus_gnt_i,
	output logic            bus_req_o,
	output mshr_req_t       bus_cmd_o
);

	// ------------------------------
	// queue to command stage
	// ------------------------------
	logic      head_vld;
	mshr_req_t head_req;
	logic      iss_ack;

	mshr_iss #(
		.MSHR_NUM(MSHR_NUM)
	) mshr_iss_i (
		.clk        (clk),
		.rst        (rst),
		.alloc_en_i (alloc_en_i),
		.alloc_req_i(alloc_req_i),
		.iss_ack_i  (iss_ack),
		.iss_vld_o  (head_vld),
		.iss_req_o  (head_req),
		.full_o     (full_o),
		.sq_addr_i  (sq_addr_i),
		.sq_hit_o   (sq_hit_o),
		.lq_addr_i  (lq_addr_i),
		.lq_hit_o   (lq_hit_o),
		.lq_fwd_o   (lq_fwd_o)
	);

	// holds one command on the bus
	bus_cmd_stage bus_cmd_i (
		.clk       (clk),
		.rst       (rst),
		.head_vld_i(head_vld),
		.head_req_i(head_req),
		.iss_ack_o (iss_ack),
		.bus_gnt_i (bus_gnt_i),
		.bus_req_o (bus_req_o),
		.bus_cmd_o (bus_cmd_o)
	);

endmodule : dcache_miss_top

`default_nettype wire

//--- tb_checker.sv
// compares once per cycle at SAMPLE_DLY after the rising edge; bus command ignored while no request
`timescale 1ns/1ps
`default_nettype none

module tb_checker import dcache_pkg::*; #(
	parameter int SAMPLE_DLY = 38
) (
	input  wire logic        clk,
	input  wire logic        chk_en_i,
	input  wire logic [31:0] line_no_i,

	// observed DUT outputs
	input  wire logic        full_i,
	input  wire logic        sq_hit_i,
	input  wire logic        lq_hit_i,
	input  wire lq_fwd_t     lq_fwd_i,
	input  wire logic        bus_req_i,
	input  wire mshr_req_t   bus_cmd_i,

	// expected values from the golden line
	input  wire logic        exp_full_i,
	input  wire logic        exp_sq_hit_i,
	input  wire logic        exp_lq_hit_i,
	input  wire lq_fwd_t     exp_lq_fwd_i,
	input  wire logic        exp_bus_req_i,
	input  wire mshr_req_t   exp_bus_cmd_i,

	output int               check_cnt_o,
	output int               err_cnt_o
);

	// ------------------------------
	// one field compare
	// ------------------------------
	// !== so an X on an output also counts
	task automatic compare_field(input string name, input logic [WORD_W-1:0] got,
		input logic [WORD_W-1:0] want);
		check_cnt_o++;
		if (got !== want) begin
			err_cnt_o++;
			$display("Mismatch at golden line %0d: %s got %0h expected %0h",
				line_no_i, name, got, want);
		end
	endtask

	task automatic compare_outputs();
		compare_field("full_o", WORD_W'(full_i), WORD_W'(exp_full_i));
		compare_field("sq_hit_o", WORD_W'(sq_hit_i), WORD_W'(exp_sq_hit_i));
		compare_field("lq_hit_o", WORD_W'(lq_hit_i), WORD_W'(exp_lq_hit_i));
		// no hit must give zero data with NONE
		compare_field("lq_fwd_o.data", lq_fwd_i.data, exp_lq_fwd_i.data);
		compare_field("lq_fwd_o.message", WORD_W'(lq_fwd_i.message),
			WORD_W'(exp_lq_fwd_i.message));
		compare_field("bus_req_o", WORD_W'(bus_req_i), WORD_W'(exp_bus_req_i));
		// command register has no reset, only a live request is compared
		if (exp_bus_req_i) begin
			compare_field("bus_cmd_o.addr", WORD_W'(bus_cmd_i.addr),
				WORD_W'(exp_bus_cmd_i.addr));
			compare_field("bus_cmd_o.data", bus_cmd_i.data, exp_bus_cmd_i.data);
			compare_field("bus_cmd_o.message", WORD_W'(bus_cmd_i.message),
				WORD_W'(exp_bus_cmd_i.message));
			compare_field("bus_cmd_o.stq_c_flag", WORD_W'(bus_cmd_i.stq_c_flag),
				WORD_W'(exp_bus_cmd_i.stq_c_flag));
		end
	endtask

	// ------------------------------
	// sampling
	// ------------------------------
	// inputs move 2 ns after the edge, outputs are settled well before the next one
	initial begin
		check_cnt_o = 0;
		err_cnt_o   = 0;
		forever begin
			@(posedge clk);
			#(SAMPLE_DLY);
			if (chk_en_i) begin
				compare_outputs();
			end
		end
	end

endmodule : tb_checker

`default_nettype wire

//--- tb_top.sv
// reads mshr_golden.txt from the working directory, one data line per clock, MSHR_NUM fixed at 4
`timescale 1ns/1ps
`default_nettype none

module tb_top import dcache_pkg::*; ();

	// ------------------------------
	// run constants
	// ------------------------------
	localparam int    MSHR_NUM    = 4;
	localparam int    CLK_PERIOD  = 40;
	localparam int    DRV_DLY     = 2;
	localparam int    RST_CYCLES  = 4;
	localparam int    RST_TIMEOUT = 20;
	localparam int    MAX_LINES   = 500;
	localparam int    NUM_COLS    = 18;
	localparam string GOLDEN_FILE = "mshr_golden.txt";

	logic        clk = 1'b0;
	logic        rst;

	// DUT inputs
	logic        alloc_en;
	mshr_req_t   alloc_req;
	line_addr_t  sq_addr;
	line_addr_t  lq_addr;
	logic        bus_gnt;

	// DUT outputs
	logic        full;
	logic        sq_hit;
	logic        lq_hit;
	lq_fwd_t     lq_fwd;
	logic        bus_req;
	mshr_req_t   bus_cmd;

	// expected side, handed to the checker
	logic        chk_en;
	logic [31:0] line_no;
	logic        exp_full;
	logic        exp_sq_hit;
	logic        exp_lq_hit;
	lq_fwd_t     exp_lq_fwd;
	logic        exp_bus_req;
	mshr_req_t   exp_bus_cmd;

	int          check_cnt;
	int          mismatch_cnt;
	int          other_err;

	// raw hex columns of one golden line
	logic [WORD_W-1:0] col [NUM_COLS];

	// 40 ns clock
	always #(CLK_PERIOD / 2) clk = ~clk;

	initial begin
		rst = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		#(DRV_DLY);
		rst = 1'b0;
	end

	dcache_miss_top #(
		.MSHR_NUM(MSHR_NUM)
	) dut_i (
		.clk        (clk),
		.rst        (rst),
		.alloc_en_i (alloc_en),
		.alloc_req_i(alloc_req),
		.full_o     (full),
		.sq_addr_i  (sq_addr),
		.sq_hit_o   (sq_hit),
		.lq_addr_i  (lq_addr),
		.lq_hit_o   (lq_hit),
		.lq_fwd_o   (lq_fwd),
		.bus_gnt_i  (bus_gnt),
		.bus_req_o  (bus_req),
		.bus_cmd_o  (bus_cmd)
	);

	// samples 2 ns before each rising edge
	tb_checker #(
		.SAMPLE_DLY(CLK_PERIOD - DRV_DLY)
	) chk_i (
		.clk          (clk),
		.chk_en_i     (chk_en),
		.line_no_i    (line_no),
		.full_i       (full),
		.sq_hit_i     (sq_hit),
		.lq_hit_i     (lq_hit),
		.lq_fwd_i     (lq_fwd),
		.bus_req_i    (bus_req),
		.bus_cmd_i    (bus_cmd),
		.exp_full_i   (exp_full),
		.exp_sq_hit_i (exp_sq_hit),
		.exp_lq_hit_i (exp_lq_hit),
		.exp_lq_fwd_i (exp_lq_fwd),
		.exp_bus_req_i(exp_bus_req),
		.exp_bus_cmd_i(exp_bus_cmd),
		.check_cnt_o  (check_cnt),
		.err_cnt_o    (mismatch_cnt)
	);

	// ------------------------------
	// stimulus helpers
	// ------------------------------
	task automatic drive_idle();
		alloc_en    = 1'b0;
		alloc_req   = '0;
		sq_addr     = '0;
		lq_addr     = '0;
		bus_gnt     = 1'b0;
		chk_en      = 1'b0;
		line_no     = '0;
		exp_full    = 1'b0;
		exp_sq_hit  = 1'b0;
		exp_lq_hit  = 1'b0;
		exp_lq_fwd  = '0;
		exp_bus_req = 1'b0;
		exp_bus_cmd = '0;
	endtask

	// columns 0..7 are inputs, 8..17 the expected outputs
	task automatic apply_line();
		alloc_en               = col[0][0];
		alloc_req.addr         = col[1][TAG_W+IDX_W-1:0];
		alloc_req.data         = col[2];
		alloc_req.message      = message_t'(col[3][1:0]);
		alloc_req.stq_c_flag   = col[4][0];
		sq_addr                = col[5][TAG_W+IDX_W-1:0];
		lq_addr                = col[6][TAG_W+IDX_W-1:0];
		bus_gnt                = col[7][0];
		exp_full               = col[8][0];
		exp_sq_hit             = col[9][0];
		exp_lq_hit             = col[10][0];
		exp_lq_fwd.data        = col[11];
		exp_lq_fwd.message     = message_t'(col[12][1:0]);
		exp_bus_req            = col[13][0];
		exp_bus_cmd.addr       = col[14][TAG_W+IDX_W-1:0];
		exp_bus_cmd.data       = col[15];
		exp_bus_cmd.message    = message_t'(col[16][1:0]);
		exp_bus_cmd.stq_c_flag = col[17][0];
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin
		int    fd;
		int    rc;
		int    n;
		int    lines;
		int    wait_cyc;
		string line;

		drive_idle();
		other_err = 0;

		// reset release, X counts as still in reset
		wait_cyc = 0;
		do begin
			@(posedge clk);
			wait_cyc++;
		end while (rst !== 1'b0 && wait_cyc < RST_TIMEOUT);
		if (rst !== 1'b0) begin
			$display("reset was not released within %0d cycles", RST_TIMEOUT);
			other_err++;
		end

		fd = $fopen(GOLDEN_FILE, "r");
		if (fd == 0) begin
			$display("cannot open golden file %s", GOLDEN_FILE);
			other_err++;
		end else begin
			lines = 0;
			while (!$feof(fd) && lines < MAX_LINES) begin
				rc = $fgets(line, fd);
				lines++;
				// comments and blank lines take no cycle
				if (rc == 0 || line.len() < 2 || line.getc(0) == "#") begin
					continue;
				end
				n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7], col[8],
					col[9], col[10], col[11], col[12], col[13], col[14], col[15], col[16],
					col[17]);
				if (n != NUM_COLS) begin
					$display("golden line %0d has %0d fields, %0d needed", lines, n, NUM_COLS);
					other_err++;
					continue;
				end
				#(DRV_DLY);
				apply_line();
				line_no = lines;
				chk_en  = 1'b1;
				@(posedge clk);
			end
			if (!$feof(fd)) begin
				$display("golden file still not at its end after %0d lines", MAX_LINES);
				other_err++;
			end
			$fclose(fd);
		end

		// last sample has already landed before this edge
		#(DRV_DLY);
		chk_en = 1'b0;
		if (check_cnt == 0) begin
			$display("no output was compared during the run");
			other_err++;
		end
		$display("checks %0d, mismatches %0d, other errors %0d",
			check_cnt, mismatch_cnt, other_err);
		if (mismatch_cnt == 0 && other_err == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule : tb_top

`default_nettype wire

//--- mshr_golden.txt
# in:  alloc_en alloc_addr alloc_data alloc_msg alloc_stqc sq_addr lq_addr bus_gnt
# exp: full sq_hit lq_hit fwd_data fwd_msg bus_req cmd_addr cmd_data cmd_msg cmd_stqc
0 0000 00 0 0 0000 0000 0  0 0 0 00 0 0 0000 00 0 0
0 0000 00 0 0 0000 0000 0  0 0 0 00 0 0 0000 00 0 0
1 0101 11 1 0 0000 0000 1  0 0 0 00 0 0 0000 00 0 0
1 0202 22 2 0 0000 0000 1  0 0 0 00 0 0 0000 00 0 0
1 0303 33 2 0 0000 0000 1  0 0 0 00 0 1 0101 11 1 0
0 0000 00 0 0 0000 0000 1  0 0 0 00 0 1 0202 22 2 0
0 0000 00 0 0 0000 0000 1  0 0 0 00 0 1 0303 33 2 0
0 0000 00 0 0 0000 0000 0  0 0 0 00 0 0 0000 00 0 0
1 0a01 a1 2 0 0b02 0b02 0  0 0 0 00 0 0 0000 00 0 0
1 0b02 b2 2 0 0b02 0b02 0  0 0 0 00 0 0 0000 00 0 0
1 0b02 b3 2 0 0b02 0b02 0  0 1 1 b2 2 1 0a01 a1 2 0
1 0b02 b4 2 1 0b02 0b02 0  0 1 1 b3 2 1 0a01 a1 2 0
1 0c03 c5 1 0 0b02 0b02 0  0 1 1 b3 2 1 0a01 a1 2 0
0 0000 00 0 0 0b02 0b02 0  1 1 1 b3 2 1 0a01 a1 2 0
0 0000 00 0 0 0c03 0c03 0  1 0 0 00 0 1 0a01 a1 2 0
0 0000 00 0 0 0a01 0b03 0  1 0 0 00 0 1 0a01 a1 2 0
0 0000 00 0 0 0b02 0b02 1  1 1 1 b3 2 1 0a01 a1 2 0
0 0000 00 0 0 0b02 0b02 1  0 1 1 b3 2 1 0b02 b2 2 0
0 0000 00 0 0 0b02 0b02 1  0 1 0 00 0 1 0b02 b3 2 0
0 0000 00 0 0 0b02 0b02 1  0 0 0 00 0 1 0b02 b4 2 1
0 0000 00 0 0 0b02 0b02 1  0 0 0 00 0 1 0c03 c5 1 0
0 0000 00 0 0 0000 0000 0  0 0 0 00 0 0 0000 00 0 0
1 0d04 d1 3 0 0000 0000 1  0 0 0 00 0 0 0000 00 0 0
1 0d05 d2 1 0 0000 0000 1  0 0 0 00 0 0 0000 00 0 0
0 0000 00 0 0 0000 0000 1  0 0 0 00 0 1 0d04 d1 3 0
0 0000 00 0 0 0000 0000 1  0 0 0 00 0 1 0d05 d2 1 0
1 0e01 e1 2 0 0f0f 0f0f 0  0 0 0 00 0 0 0000 00 0 0
1 0f0f f2 2 0 0f0f 0f0f 0  0 0 0 00 0 0 0000 00 0 0
1 0f0f f3 2 1 0f0f 0f0f 0  0 1 1 f2 2 1 0e01 e1 2 0
1 1f0f f4 2 0 0f0f 0f0f 0  0 1 1 f2 2 1 0e01 e1 2 0
1 0f0f f5 2 0 0f0f 0f0f 0  0 1 1 f2 2 1 0e01 e1 2 0
0 0000 00 0 0 0f0f 0f0f 0  1 1 1 f5 2 1 0e01 e1 2 0
0 0000 00 0 0 1f0f 1f0f 0  1 1 1 f4 2 1 0e01 e1 2 0
0 0000 00 0 0 0f0f 0f0f 1  1 1 1 f5 2 1 0e01 e1 2 0
0 0000 00 0 0 0f0f 0f0f 1  0 1 1 f5 2 1 0f0f f2 2 0
0 0000 00 0 0 0f0f 0f0f 1  0 1 1 f5 2 1 0f0f f3 2 1
0 0000 00 0 0 0f0f 0f0f 1  0 1 1 f5 2 1 1f0f f4 2 0
0 0000 00 0 0 0f0f 0f0f 1  0 0 0 00 0 1 0f0f f5 2 0
0 0000 00 0 0 0000 0000 0  0 0 0 00 0 0 0000 00 0 0

//--- verilog.f
dcache_pkg.sv
rps_sel.sv
mshr_iss.sv
bus_cmd_stage.sv
dcache_miss_top.sv
tb_checker.sv
tb_top.sv

//--- Makefile
# Verilator build and run of the miss-issue testbench

VERILATOR ?= verilator
TOP       ?= tb_top
LOG       ?= sim.log
FLIST     ?= verilog.f
OBJ_DIR   ?= obj_dir
GOLDEN    ?= mshr_golden.txt
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN) $(GOLDEN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
